/* source/gpio_bus_pkg.sv */
`default_nettype none

package gpio_bus_pkg;

	// Width of one Wishbone data word
	localparam int WORD_BITS = 16;

	// One select line per byte of the data word
	localparam int SEL_BITS = WORD_BITS / 8;

	// Word address width, the byte offset bit is not carried
	localparam int ADDR_BITS = 15;

	// Address bit that splits the map into data and command halves
	// 4 data words below it, 4 command words above it, 16 bytes in total
	localparam int MAP_HALF_BIT = 2;

endpackage

`default_nettype wire

/* source/gpio_cmd_pkg.sv */
`default_nettype none

package gpio_cmd_pkg;

	// Command word is one command bit on top of the argument field
	// Argument fills the rest of the 16-bit word
	localparam int ARG_BITS = 15;

	// Command codes, found in the top bit of a command write
	localparam logic CMD_CONFIGURE_IO = 1'b0;
	localparam logic CMD_SET_DEBOUNCE = 1'b1;

	// Debounce threshold after reset
	// Zero means a pin change passes after the synchronizer only
	localparam logic [ARG_BITS-1:0] DBNC_RESET = '0;

endpackage

`default_nettype wire

/* source/gpio_debouncer.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_debouncer
	import gpio_cmd_pkg::*;
(
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                pin_i,
	input  logic [ARG_BITS-1:0] thresh_i,
	output logic                pin_o
);

	// Two-flop synchronizer for the raw pin
	logic pin_meta;
	logic pin_sync;

	// Consecutive cycles in which pin_sync differs from pin_o
	logic [ARG_BITS-1:0] stable_cnt;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pin_meta <= 1'b0;
			pin_sync <= 1'b0;
		end else begin
			pin_meta <= pin_i;
			pin_sync <= pin_meta;
		end
	end

	// Output follows the synchronized pin once the difference
	// has lasted more than thresh_i cycles
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			stable_cnt <= '0;
			pin_o      <= 1'b0;
		end else if (pin_sync == pin_o) begin
			// Back to equality, any count so far was a glitch
			stable_cnt <= '0;
		end else if (stable_cnt >= thresh_i) begin
			// >= also covers a threshold lowered mid-count
			pin_o      <= pin_sync;
			stable_cnt <= '0;
		end else begin
			stable_cnt <= stable_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* source/gpio_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_regs
	import gpio_bus_pkg::*, gpio_cmd_pkg::*;
#(
	parameter int IO_COUNT = 8,
	parameter int CLK_FREQ = 125000000
) (
	input  logic                 clk_i,
	input  logic                 rst_i,

	input  logic                 wb_cyc_i,
	input  logic                 wb_stb_i,
	input  logic                 wb_we_i,
	input  logic [ADDR_BITS-1:0] wb_adr_i,
	// Byte selects are accepted and ignored, all registers are full words
	input  logic [SEL_BITS-1:0]  wb_sel_i,
	input  logic [WORD_BITS-1:0] wb_dat_i,
	output logic                 wb_ack_o,
	output logic [WORD_BITS-1:0] wb_dat_o,

	input  logic [IO_COUNT-1:0]  pin_db_i,
	output logic [IO_COUNT-1:0]  o_o,
	output logic [IO_COUNT-1:0]  t_o,
	output logic [ARG_BITS-1:0]  dbnc_thresh_o
);

	// Pending stage, filled on the accepting edge
	logic                 req_vld;
	logic                 req_we;
	logic                 req_cmd_half;
	logic [WORD_BITS-1:0] req_dat;

	// Execute stage, holds the decoded request
	logic                 exe_vld;
	logic                 exe_rd;
	logic                 exe_rd_cmd;
	logic                 exe_wr_data;
	logic                 exe_cfg_io;
	logic                 exe_set_dbnc;
	logic [WORD_BITS-1:0] exe_dat;

	// Last command bit and its response
	logic [WORD_BITS-1:0] resp;

	logic idle;
	logic accept;

	// No new request while one is in flight or being acked
	// so a strobe held until ack never runs twice
	assign idle   = !req_vld && !exe_vld && !wb_ack_o;
	assign accept = idle && wb_cyc_i && wb_stb_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			req_vld <= 1'b0;
		end else begin
			req_vld <= accept;
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			req_we       <= wb_we_i;
			req_cmd_half <= wb_adr_i[MAP_HALF_BIT];
			req_dat      <= wb_dat_i;
		end
	end

	// Decode by map half, write enable and command bit
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			exe_vld      <= 1'b0;
			exe_rd       <= 1'b0;
			exe_rd_cmd   <= 1'b0;
			exe_wr_data  <= 1'b0;
			exe_cfg_io   <= 1'b0;
			exe_set_dbnc <= 1'b0;
		end else begin
			exe_vld      <= req_vld;
			exe_rd       <= req_vld && !req_we;
			exe_rd_cmd   <= req_vld && !req_we && req_cmd_half;
			exe_wr_data  <= req_vld && req_we && !req_cmd_half;
			exe_cfg_io   <= req_vld && req_we && req_cmd_half &&
				(req_dat[WORD_BITS-1] == CMD_CONFIGURE_IO);
			exe_set_dbnc <= req_vld && req_we && req_cmd_half &&
				(req_dat[WORD_BITS-1] == CMD_SET_DEBOUNCE);
		end
	end

	always_ff @(posedge clk_i) begin
		if (req_vld) begin
			exe_dat <= req_dat;
		end
	end

	// One-cycle ack, two edges after acceptance
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wb_ack_o <= 1'b0;
		end else begin
			wb_ack_o <= exe_vld;
		end
	end

	// Register effects land on the same edge as the ack
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			o_o <= '0;
		end else if (exe_wr_data) begin
			o_o <= exe_dat[IO_COUNT-1:0];
		end
	end

	// Direction bitmap, 1 means output
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			t_o <= '0;
		end else if (exe_cfg_io) begin
			t_o <= exe_dat[IO_COUNT-1:0];
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			dbnc_thresh_o <= DBNC_RESET;
		end else if (exe_set_dbnc) begin
			dbnc_thresh_o <= exe_dat[ARG_BITS-1:0];
		end
	end

	// Response word, pin count or clock frequency cut to 15 bits
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			resp <= '0;
		end else if (exe_cfg_io) begin
			resp <= {CMD_CONFIGURE_IO, ARG_BITS'(IO_COUNT)};
		end else if (exe_set_dbnc) begin
			resp <= {CMD_SET_DEBOUNCE, ARG_BITS'(CLK_FREQ)};
		end
	end

	// Read data, valid while ack is high
	// Data half gives the debounced pins zero-extended
	always_ff @(posedge clk_i) begin
		if (exe_rd) begin
			wb_dat_o <= exe_rd_cmd ? resp : WORD_BITS'(pin_db_i);
		end
	end

endmodule

`default_nettype wire

/* source/gpio_irq.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_irq #(
	parameter int IO_COUNT = 8
) (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic [IO_COUNT-1:0] pin_db_i,
	input  logic [IO_COUNT-1:0] dir_i,
	input  logic                irq_rdy_i,
	output logic                irq_o
);

	// Debounced pins one cycle ago
	logic [IO_COUNT-1:0] pin_db_q;

	// Changed bits, output-configured pins masked off
	logic [IO_COUNT-1:0] pin_chg;

	// Sticky per-pin change flags
	logic [IO_COUNT-1:0] chg_pend;

	// Registered ready, for falling-edge detection
	logic rdy_q;
	logic rdy_fall;

	assign pin_chg  = (pin_db_i ^ pin_db_q) & ~dir_i;
	assign rdy_fall = rdy_q && !irq_rdy_i;
	assign irq_o    = |chg_pend;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pin_db_q <= '0;
			rdy_q    <= 1'b0;
		end else begin
			pin_db_q <= pin_db_i;
			rdy_q    <= irq_rdy_i;
		end
	end

	// Clear on a ready fall, but keep a change from the same cycle
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			chg_pend <= '0;
		end else if (rdy_fall) begin
			chg_pend <= pin_chg;
		end else begin
			chg_pend <= chg_pend | pin_chg;
		end
	end

endmodule

`default_nettype wire

/* source/gpio_top.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_top
	import gpio_bus_pkg::*, gpio_cmd_pkg::*;
#(
	parameter int IO_COUNT = 8,
	parameter int CLK_FREQ = 125000000
) (
	input  logic                 clk_i,
	input  logic                 rst_i,

	input  logic                 wb_cyc_i,
	input  logic                 wb_stb_i,
	input  logic                 wb_we_i,
	input  logic [ADDR_BITS-1:0] wb_adr_i,
	input  logic [SEL_BITS-1:0]  wb_sel_i,
	input  logic [WORD_BITS-1:0] wb_dat_i,
	output logic                 wb_ack_o,
	output logic [WORD_BITS-1:0] wb_dat_o,

	input  logic [IO_COUNT-1:0]  pin_i,
	output logic [IO_COUNT-1:0]  pin_o,
	output logic [IO_COUNT-1:0]  pin_dir_o,

	output logic                 irq_o,
	input  logic                 irq_rdy_i
);

	// Shared threshold for all debouncers
	logic [ARG_BITS-1:0] dbnc_thresh;

	// Debounced pin states
	logic [IO_COUNT-1:0] pin_db;

	gpio_regs #(
		.IO_COUNT (IO_COUNT),
		.CLK_FREQ (CLK_FREQ)
	) u_regs (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.wb_cyc_i      (wb_cyc_i),
		.wb_stb_i      (wb_stb_i),
		.wb_we_i       (wb_we_i),
		.wb_adr_i      (wb_adr_i),
		.wb_sel_i      (wb_sel_i),
		.wb_dat_i      (wb_dat_i),
		.wb_ack_o      (wb_ack_o),
		.wb_dat_o      (wb_dat_o),
		.pin_db_i      (pin_db),
		.o_o           (pin_o),
		.t_o           (pin_dir_o),
		.dbnc_thresh_o (dbnc_thresh)
	);

	// One debouncer per pin
	for (genvar i = 0; i < IO_COUNT; i++) begin : gen_dbnc
		gpio_debouncer u_dbnc (
			.clk_i    (clk_i),
			.rst_i    (rst_i),
			.pin_i    (pin_i[i]),
			.thresh_i (dbnc_thresh),
			.pin_o    (pin_db[i])
		);
	end

	// Direction doubles as the interrupt mask
	gpio_irq #(
		.IO_COUNT (IO_COUNT)
	) u_irq (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.pin_db_i  (pin_db),
		.dir_i     (pin_dir_o),
		.irq_rdy_i (irq_rdy_i),
		.irq_o     (irq_o)
	);

endmodule

`default_nettype wire

/* verification/gpio_top_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_top_assertions
	import gpio_bus_pkg::*, gpio_cmd_pkg::*;
#(
	parameter int IO_COUNT = 8
) (
	input logic                 clk_i,
	input logic                 rst_i,
	input logic                 wb_cyc_i,
	input logic                 wb_stb_i,
	input logic                 wb_we_i,
	input logic [ADDR_BITS-1:0] wb_adr_i,
	input logic [WORD_BITS-1:0] wb_dat_i,
	input logic                 wb_ack_o,
	input logic [IO_COUNT-1:0]  pin_o,
	input logic [IO_COUNT-1:0]  pin_dir_o,
	input logic [IO_COUNT-1:0]  pin_db,
	input logic                 irq_o,
	input logic                 irq_rdy_i
);

	// Master view of the bus, one transfer open at a time
	logic in_flight;
	logic req_start;

	// Kind and data of the last accepted request
	logic                 pend_wr_data;
	logic                 pend_cfg_io;
	logic [WORD_BITS-1:0] pend_dat;

	// Debounced pins one cycle ago, for change detection
	logic [IO_COUNT-1:0] prev_db;
	logic                chg_in;

	// One failure counter per assertion
	int unsigned ack_fails   = 0;
	int unsigned out_fails   = 0;
	int unsigned dir_fails   = 0;
	int unsigned hold_fails  = 0;
	int unsigned rise_fails  = 0;
	int unsigned clear_fails = 0;
	int unsigned fail_cnt;

	assign req_start = wb_cyc_i && wb_stb_i && !in_flight && !wb_ack_o;
	// Only input-configured pins count
	assign chg_in    = |((pin_db ^ prev_db) & ~pin_dir_o);
	assign fail_cnt  = ack_fails + out_fails + dir_fails + hold_fails + rise_fails + clear_fails;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			in_flight    <= 1'b0;
			pend_wr_data <= 1'b0;
			pend_cfg_io  <= 1'b0;
			pend_dat     <= '0;
			prev_db      <= '0;
		end else begin
			prev_db <= pin_db;
			if (req_start) begin
				in_flight    <= 1'b1;
				pend_wr_data <= wb_we_i && !wb_adr_i[MAP_HALF_BIT];
				pend_cfg_io  <= wb_we_i && wb_adr_i[MAP_HALF_BIT] &&
					(wb_dat_i[WORD_BITS-1] == CMD_CONFIGURE_IO);
				pend_dat     <= wb_dat_i;
			end else if (wb_ack_o) begin
				in_flight <= 1'b0;
			end
		end
	end

	// Ack one cycle long, two edges after acceptance, never without a request
	ack_timing: assert property (@(posedge clk_i) disable iff (rst_i)
		wb_ack_o == $past(req_start, 3))
	else begin
		$error("ack did not follow the accepted request by exactly two cycles");
		ack_fails++;
	end

	out_value: assert property (@(posedge clk_i) disable iff (rst_i)
		wb_ack_o && pend_wr_data |-> pin_o == pend_dat[IO_COUNT-1:0])
	else begin
		$error("pin_o differs from the written data in the ack cycle");
		out_fails++;
	end

	dir_value: assert property (@(posedge clk_i) disable iff (rst_i)
		wb_ack_o && pend_cfg_io |-> pin_dir_o == pend_dat[IO_COUNT-1:0])
	else begin
		$error("pin_dir_o differs from the configure-IO bitmap in the ack cycle");
		dir_fails++;
	end

	// Registers only move together with an ack
	reg_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		!wb_ack_o |-> $stable(pin_o) && $stable(pin_dir_o))
	else begin
		$error("pin_o or pin_dir_o changed outside an ack cycle");
		hold_fails++;
	end

	irq_cause: assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(irq_o) |-> $past(chg_in))
	else begin
		$error("irq_o rose without a change on an input pin");
		rise_fails++;
	end

	// A change in the clearing cycle keeps the request up
	irq_clear: assert property (@(posedge clk_i) disable iff (rst_i)
		$fell(irq_rdy_i) && !chg_in |=> !irq_o)
	else begin
		$error("irq_o not low one cycle after irq_rdy_i fell");
		clear_fails++;
	end

endmodule

`default_nettype wire

/* verification/tb_gpio_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_gpio_top
	import gpio_bus_pkg::*, gpio_cmd_pkg::*;
();

	localparam int IO_COUNT   = 8;
	localparam int CLK_FREQ   = 125000000;
	localparam int DBNC_THR   = 10;
	// Well above the length of all tests together
	localparam int MAX_CYCLES = 4000;
	localparam int unsigned SEED = 32'hd58d;

	localparam logic [ADDR_BITS-1:0] DATA_ADR = '0;
	localparam logic [ADDR_BITS-1:0] CMD_ADR  = ADDR_BITS'(1 << MAP_HALF_BIT);

	// Pin edge to irq_o, plus some margin
	localparam int IRQ_WAIT = DBNC_THR + 3 + 1 + 4;

	logic                 clk_i = 1'b0;
	logic                 rst_i;
	logic                 wb_cyc_i;
	logic                 wb_stb_i;
	logic                 wb_we_i;
	logic [ADDR_BITS-1:0] wb_adr_i;
	logic [SEL_BITS-1:0]  wb_sel_i;
	logic [WORD_BITS-1:0] wb_dat_i;
	logic                 wb_ack_o;
	logic [WORD_BITS-1:0] wb_dat_o;
	logic [IO_COUNT-1:0]  pin_i;
	logic [IO_COUNT-1:0]  pin_o;
	logic [IO_COUNT-1:0]  pin_dir_o;
	logic                 irq_o;
	logic                 irq_rdy_i;

	int                   errors    = 0;
	int                   cycle_cnt = 0;
	int unsigned          seed_ret;
	logic [WORD_BITS-1:0] rd_val;
	logic [WORD_BITS-1:0] wr_word;
	logic [IO_COUNT-1:0]  dir_bits;
	logic [IO_COUNT-1:0]  lvl_bits;
	logic [IO_COUNT-1:0]  pulse_bits;

	// 8 ns clock
	always #4 clk_i = ~clk_i;

	gpio_top #(
		.IO_COUNT (IO_COUNT),
		.CLK_FREQ (CLK_FREQ)
	) DUT (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.wb_cyc_i  (wb_cyc_i),
		.wb_stb_i  (wb_stb_i),
		.wb_we_i   (wb_we_i),
		.wb_adr_i  (wb_adr_i),
		.wb_sel_i  (wb_sel_i),
		.wb_dat_i  (wb_dat_i),
		.wb_ack_o  (wb_ack_o),
		.wb_dat_o  (wb_dat_o),
		.pin_i     (pin_i),
		.pin_o     (pin_o),
		.pin_dir_o (pin_dir_o),
		.irq_o     (irq_o),
		.irq_rdy_i (irq_rdy_i)
	);

	bind gpio_top gpio_top_assertions #(.IO_COUNT(IO_COUNT)) u_chk (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.wb_cyc_i  (wb_cyc_i),
		.wb_stb_i  (wb_stb_i),
		.wb_we_i   (wb_we_i),
		.wb_adr_i  (wb_adr_i),
		.wb_dat_i  (wb_dat_i),
		.wb_ack_o  (wb_ack_o),
		.pin_o     (pin_o),
		.pin_dir_o (pin_dir_o),
		.pin_db    (pin_db),
		.irq_o     (irq_o),
		.irq_rdy_i (irq_rdy_i)
	);

	// All tasks start and end 1 ns after a rising edge
	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk_i);
			#1;
		end
	endtask

	task automatic wait_ack();
		int cnt;
		cnt = 0;
		do begin
			idle_cycles(1);
			cnt++;
		end while (!wb_ack_o && cnt < 8);
		if (!wb_ack_o) begin
			errors++;
			$display("No acknowledge within %0d cycles at %0t ns", cnt, $time);
		end
	endtask

	task automatic write_reg(input logic [ADDR_BITS-1:0] adr, input logic [WORD_BITS-1:0] dat);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = 1'b1;
		wb_adr_i = adr;
		wb_sel_i = '1;
		wb_dat_i = dat;
		// Strobe held until ack, must not write twice
		wait_ack();
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		idle_cycles(1);
	endtask

	task automatic read_reg(input logic [ADDR_BITS-1:0] adr, output logic [WORD_BITS-1:0] dat);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = 1'b0;
		wb_adr_i = adr;
		wb_sel_i = '1;
		wait_ack();
		// Read data valid while ack is high
		dat      = wb_dat_o;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		idle_cycles(1);
	endtask

	task automatic expect_equal(input string name, input logic [WORD_BITS-1:0] exp,
		input logic [WORD_BITS-1:0] act);
		if (act !== exp) begin
			errors++;
			$display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	// One-cycle low pulse on irq_rdy_i
	task automatic pulse_ready();
		irq_rdy_i = 1'b0;
		idle_cycles(1);
		irq_rdy_i = 1'b1;
	endtask

	always @(posedge clk_i) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Errors: %0d mismatches, %0d assertion failures",
				errors, DUT.u_chk.fail_cnt);
			$display("TEST FAIL");
			$finish;
		end
	end

	initial begin
		seed_ret  = $urandom(SEED);
		rst_i     = 1'b1;
		wb_cyc_i  = 1'b0;
		wb_stb_i  = 1'b0;
		wb_we_i   = 1'b0;
		wb_adr_i  = '0;
		wb_sel_i  = '0;
		wb_dat_i  = '0;
		pin_i     = '0;
		irq_rdy_i = 1'b1;
		repeat (16) @(posedge clk_i);
		#1;
		rst_i = 1'b0;
		idle_cycles(2);

		// Reset state, response word starts at zero
		expect_equal("pin_o", '0, WORD_BITS'(pin_o));
		expect_equal("pin_dir_o", '0, WORD_BITS'(pin_dir_o));
		expect_equal("irq_o", '0, WORD_BITS'(irq_o));
		read_reg(CMD_ADR, rd_val);
		expect_equal("dat_o response", '0, rd_val);

		// Random output data and direction bitmaps
		repeat (4) begin
			wr_word = WORD_BITS'($urandom);
			write_reg(DATA_ADR, wr_word);
			expect_equal("pin_o", WORD_BITS'(wr_word[IO_COUNT-1:0]), WORD_BITS'(pin_o));
			dir_bits = IO_COUNT'($urandom);
			write_reg(CMD_ADR, {CMD_CONFIGURE_IO, ARG_BITS'(dir_bits)});
			expect_equal("pin_dir_o", WORD_BITS'(dir_bits), WORD_BITS'(pin_dir_o));
		end
		// Command bit 0 on top of the pin count
		read_reg(CMD_ADR, rd_val);
		expect_equal("dat_o response", WORD_BITS'(IO_COUNT), rd_val);

		// Set-debounce answers with the clock frequency cut to 15 bits
		write_reg(CMD_ADR, {CMD_SET_DEBOUNCE, ARG_BITS'(DBNC_THR)});
		read_reg(CMD_ADR, rd_val);
		expect_equal("dat_o response",
			{CMD_SET_DEBOUNCE, ARG_BITS'(CLK_FREQ % (1 << ARG_BITS))}, rd_val);

		// Short pulse stays below the threshold, reads keep the old level
		read_reg(DATA_ADR, rd_val);
		expect_equal("dat_o pins", '0, rd_val);
		pulse_bits = IO_COUNT'($urandom) | IO_COUNT'(1);
		fork
			begin
				pin_i = pulse_bits;
				idle_cycles(5);
				pin_i = '0;
			end
			begin
				repeat (6) begin
					read_reg(DATA_ADR, rd_val);
					expect_equal("dat_o pins", '0, rd_val);
				end
			end
		join

		// Level held well past threshold plus synchronizer
		lvl_bits = IO_COUNT'($urandom);
		pin_i    = lvl_bits;
		idle_cycles(40);
		read_reg(DATA_ADR, rd_val);
		expect_equal("dat_o pins", WORD_BITS'(lvl_bits), rd_val);

		// Pin 0 output, top pin input, start from a cleared request
		write_reg(CMD_ADR, {CMD_CONFIGURE_IO, ARG_BITS'(1)});
		pulse_ready();
		idle_cycles(1);
		expect_equal("irq_o", '0, WORD_BITS'(irq_o));

		// Output pin toggle is masked
		pin_i[0] = ~pin_i[0];
		idle_cycles(IRQ_WAIT);
		expect_equal("irq_o", '0, WORD_BITS'(irq_o));

		// Input pin toggle raises the request
		pin_i[IO_COUNT-1] = ~pin_i[IO_COUNT-1];
		for (int i = 0; i < IRQ_WAIT && !irq_o; i++) begin
			idle_cycles(1);
		end
		if (!irq_o) begin
			errors++;
			$display("irq_o did not rise after an input pin change at %0t ns", $time);
		end

		// Ready pulse clears it, stable pins keep it low
		pulse_ready();
		idle_cycles(1);
		repeat (20) begin
			expect_equal("irq_o", '0, WORD_BITS'(irq_o));
			idle_cycles(1);
		end

		$display("Errors: %0d mismatches, %0d assertion failures",
			errors, DUT.u_chk.fail_cnt);
		if (errors == 0 && DUT.u_chk.fail_cnt == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
source/gpio_bus_pkg.sv
source/gpio_cmd_pkg.sv
source/gpio_debouncer.sv
source/gpio_regs.sv
source/gpio_irq.sv
source/gpio_top.sv
verification/gpio_top_assertions.sv
verification/tb_gpio_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the GPIO testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_gpio_top \
	-f flist.f -Mdir obj_dir -o sim_gpio > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

# Keep running past assertion errors so the testbench reaches its verdict
./obj_dir/sim_gpio +verilator+error+limit+1000 > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "TEST FAIL" sim.log; then
	exit 1
fi
exit 0
